// ==== common/textPkg.sv ====
// Text-mode video package with the layout defaults, glyph codes and pipeline structs
package textPkg;

	// Default text layout for a 640x480 screen
	parameter int defTextCols = 78;
	parameter int defTextRows = 9;
	parameter int defLastRowCols = 33;
	parameter int defXOrigin = 16;
	parameter int defRowPitch = 16;

	// Glyph cell is square
	parameter int glyphSize = 8;

	parameter int coordW = 10;
	parameter int cellAddrW = 10;

	// Codes past glyphBlank also render blank
	typedef enum logic [7:0] {
		glyphA = 8'd0, glyphB = 8'd1, glyphC = 8'd2, glyphD = 8'd3,
		glyphE = 8'd4, glyphF = 8'd5, glyphG = 8'd6, glyphH = 8'd7,
		glyphI = 8'd8, glyphJ = 8'd9, glyphK = 8'd10, glyphL = 8'd11,
		glyphM = 8'd12, glyphN = 8'd13, glyphO = 8'd14, glyphP = 8'd15,
		glyphQ = 8'd16, glyphR = 8'd17, glyphS = 8'd18, glyphT = 8'd19,
		glyphU = 8'd20, glyphV = 8'd21, glyphW = 8'd22, glyphX = 8'd23,
		glyphY = 8'd24, glyphZ = 8'd25,
		glyphBlank = 8'd26
	} glyphCode_t;

	// Host write strobe
	typedef struct packed {
		logic en;
		logic [cellAddrW-1:0] addr;
		glyphCode_t code;
	} charWrite_t;

	// Travels next to the memory read
	typedef struct packed {
		logic inText;
		logic [2:0] glyphRow;
		logic [2:0] glyphCol;
	} pixelTag_t;

endpackage

// ==== verilog/charRam.sv ====
// Character memory holding one glyph code per text cell, one write and one read port
module charRam #(
	parameter int depth = 702
) (
	input logic clk,
	input textPkg::charWrite_t wr,
	input logic [textPkg::cellAddrW-1:0] rdAddr,
	output textPkg::glyphCode_t rdCode
);

	textPkg::glyphCode_t mem [depth];

	// Host side
	always_ff @(posedge clk) begin
		if (wr.en) begin
			mem[wr.addr] <= wr.code;
		end
	end

	// Read-first, so a same-edge write shows up one cycle later
	always_ff @(posedge clk) begin
		rdCode <= mem[rdAddr];
	end

endmodule

// ==== verilog/fontRom.sv ====
// Font lookup returning one 8-pixel row of a letter glyph, MSB on the left
module fontRom (
	input textPkg::glyphCode_t code,
	input logic [2:0] row,
	output logic [7:0] bits
);

	// Row 0 sits at index 0
	logic [0:7][7:0] glyph;

	always_comb begin
		case (code)
			textPkg::glyphA: glyph = {8'h00, 8'h78, 8'h84, 8'h84,
				8'hFC, 8'h84, 8'h84, 8'h84};
			textPkg::glyphB: glyph = {8'h00, 8'hF0, 8'h88, 8'h88,
				8'hF8, 8'h84, 8'h84, 8'hF8};
			textPkg::glyphC: glyph = {8'h00, 8'h7E, 8'h80, 8'h80,
				8'h80, 8'h80, 8'h80, 8'h7E};
			textPkg::glyphD: glyph = {8'h00, 8'hF8, 8'h84, 8'h84,
				8'h84, 8'h84, 8'h84, 8'hF8};
			textPkg::glyphE: glyph = {8'h00, 8'hFE, 8'h80, 8'h80,
				8'hFC, 8'h80, 8'h80, 8'hFE};
			textPkg::glyphF: glyph = {8'h00, 8'hFE, 8'h80, 8'h80,
				8'hFC, 8'h80, 8'h80, 8'h80};
			textPkg::glyphG: glyph = {8'h00, 8'h7E, 8'h80, 8'h80,
				8'h86, 8'h82, 8'h82, 8'h7C};
			textPkg::glyphH: glyph = {8'h00, 8'h82, 8'h82, 8'h82,
				8'hFE, 8'h82, 8'h82, 8'h82};
			textPkg::glyphI: glyph = {8'h00, 8'hFE, 8'h10, 8'h10,
				8'h10, 8'h10, 8'h10, 8'hFE};
			textPkg::glyphJ: glyph = {8'h00, 8'hFE, 8'h08, 8'h08,
				8'h08, 8'h88, 8'h88, 8'h70};
			textPkg::glyphK: glyph = {8'h00, 8'h90, 8'hA0, 8'hC0,
				8'hC0, 8'hA0, 8'h90, 8'h88};
			textPkg::glyphL: glyph = {8'h00, 8'h80, 8'h80, 8'h80,
				8'h80, 8'h80, 8'h80, 8'hFE};
			textPkg::glyphM: glyph = {8'h00, 8'h82, 8'hC6, 8'hAA,
				8'h92, 8'h82, 8'h82, 8'h82};
			textPkg::glyphN: glyph = {8'h00, 8'h82, 8'hC2, 8'hA2,
				8'h92, 8'h8A, 8'h86, 8'h82};
			textPkg::glyphO: glyph = {8'h00, 8'h7C, 8'h82, 8'h82,
				8'h82, 8'h82, 8'h82, 8'h7C};
			textPkg::glyphP: glyph = {8'h00, 8'hFC, 8'h82, 8'h82,
				8'hFC, 8'h80, 8'h80, 8'h80};
			textPkg::glyphQ: glyph = {8'h00, 8'h7E, 8'h82, 8'h82,
				8'h92, 8'h8A, 8'h86, 8'h7E};
			textPkg::glyphR: glyph = {8'h00, 8'hFC, 8'h82, 8'h82,
				8'hFC, 8'h98, 8'h8C, 8'h86};
			textPkg::glyphS: glyph = {8'h00, 8'h7C, 8'h82, 8'h80,
				8'h7C, 8'h02, 8'h82, 8'h7C};
			textPkg::glyphT: glyph = {8'h00, 8'hFE, 8'h10, 8'h10,
				8'h10, 8'h10, 8'h10, 8'h10};
			textPkg::glyphU: glyph = {8'h00, 8'h82, 8'h82, 8'h82,
				8'h82, 8'h82, 8'h82, 8'hFE};
			textPkg::glyphV: glyph = {8'h00, 8'h82, 8'h82, 8'h44,
				8'h44, 8'h28, 8'h28, 8'h10};
			textPkg::glyphW: glyph = {8'h00, 8'h82, 8'h82, 8'h82,
				8'h92, 8'h54, 8'h54, 8'h28};
			textPkg::glyphX: glyph = {8'h00, 8'h82, 8'h44, 8'h28,
				8'h10, 8'h28, 8'h44, 8'h82};
			textPkg::glyphY: glyph = {8'h00, 8'h82, 8'h44, 8'h28,
				8'h10, 8'h20, 8'h40, 8'h80};
			textPkg::glyphZ: glyph = {8'h00, 8'hFE, 8'h04, 8'h08,
				8'h10, 8'h20, 8'h40, 8'hFE};
			textPkg::glyphBlank: glyph = '0;
			// Codes 27 and up
			default: glyph = '0;
		endcase
	end

	assign bits = glyph[row];

endmodule

// ==== verilog/textCellMap.sv ====
// Maps a pixel coordinate onto a text cell address and a position inside its glyph
module textCellMap #(
	parameter int textCols = 78,
	parameter int textRows = 9,
	parameter int lastRowCols = 33,
	parameter int xOrigin = 16,
	parameter int rowPitch = 16
) (
	input logic clk,
	input logic rstN,
	input logic [textPkg::coordW-1:0] x,
	input logic [textPkg::coordW-1:0] y,
	output logic [textPkg::cellAddrW-1:0] cellAddr,
	output textPkg::pixelTag_t tag
);

	localparam int coordW = textPkg::coordW;
	localparam int idxW = 2 * coordW;

	logic [coordW-1:0] xRel;
	logic [coordW-1:0] col;
	logic [coordW-1:0] row;
	logic [coordW-1:0] yOff;
	logic [idxW-1:0] cellIdx;
	logic colOk;
	logic inText;

	assign xRel = x - coordW'(xOrigin);
	assign col = coordW'(xRel / textPkg::glyphSize);
	assign row = coordW'(y / rowPitch);
	assign yOff = coordW'(y % rowPitch);

	// Last text row is shorter
	assign colOk = (row == coordW'(textRows - 1)) ? (col < lastRowCols) : (col < textCols);
	assign inText = (x >= xOrigin) && (yOff < textPkg::glyphSize) && (row < textRows) && colOk;

	assign cellIdx = idxW'(row * textCols + col);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			cellAddr <= '0;
			tag <= '0;
		end else begin
			// Park the read on cell 0 outside text
			cellAddr <= inText ? cellIdx[textPkg::cellAddrW-1:0] : '0;
			tag.inText <= inText;
			tag.glyphRow <= yOff[2:0];
			tag.glyphCol <= xRel[2:0];
		end
	end

endmodule

// ==== verilog/videoGen.sv ====
// Text-mode pixel generator, three-stage pipeline from coordinate to colour
module videoGen #(
	parameter int textCols = textPkg::defTextCols,
	parameter int textRows = textPkg::defTextRows,
	parameter int lastRowCols = textPkg::defLastRowCols,
	parameter int xOrigin = textPkg::defXOrigin,
	parameter int rowPitch = textPkg::defRowPitch
) (
	input logic clk,
	input logic rstN,
	input logic [textPkg::coordW-1:0] x,
	input logic [textPkg::coordW-1:0] y,
	input textPkg::charWrite_t wr,
	output logic [7:0] r,
	output logic [7:0] g,
	output logic [7:0] b
);

	logic [textPkg::cellAddrW-1:0] cellAddr;
	textPkg::pixelTag_t mapTag;
	textPkg::pixelTag_t tagDly;
	textPkg::glyphCode_t rdCode;
	logic [7:0] glyphBits;
	logic pixelOn;

	// Stage 1
	textCellMap #(
		.textCols(textCols),
		.textRows(textRows),
		.lastRowCols(lastRowCols),
		.xOrigin(xOrigin),
		.rowPitch(rowPitch)
	) cellMap_i (
		.clk(clk),
		.rstN(rstN),
		.x(x),
		.y(y),
		.cellAddr(cellAddr),
		.tag(mapTag)
	);

	// Stage 2
	charRam #(
		.depth(textCols * textRows)
	) charRam_i (
		.clk(clk),
		.wr(wr),
		.rdAddr(cellAddr),
		.rdCode(rdCode)
	);

	// Keep tag aligned with the memory output
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			tagDly <= '0;
		end else begin
			tagDly <= mapTag;
		end
	end

	// Stage 3
	fontRom fontRom_i (
		.code(rdCode),
		.row(tagDly.glyphRow),
		.bits(glyphBits)
	);

	// MSB is the leftmost pixel
	assign pixelOn = tagDly.inText && glyphBits[3'd7 - tagDly.glyphCol];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			r <= '0;
			g <= '0;
			b <= '0;
		end else begin
			r <= {8{pixelOn}};
			g <= {8{pixelOn}};
			b <= {8{pixelOn}};
		end
	end

endmodule

// ==== sim/glyphModel.svh ====
// Testbench font copy and reference pixel function for the text-mode generator
`ifndef GLYPH_MODEL_SVH
`define GLYPH_MODEL_SVH

localparam int numCells = (textPkg::defTextRows - 1) * textPkg::defTextCols
	+ textPkg::defLastRowCols;

// Shadow of every code written into the character memory
logic [7:0] shadow [numCells];

// Eight rows, row 0 in the top byte
function automatic logic [63:0] glyphBitmap(input logic [7:0] code);
	case (code)
		8'd0: return 64'h0078_8484_FC84_8484;
		8'd1: return 64'h00F0_8888_F884_84F8;
		8'd2: return 64'h007E_8080_8080_807E;
		8'd3: return 64'h00F8_8484_8484_84F8;
		8'd4: return 64'h00FE_8080_FC80_80FE;
		8'd5: return 64'h00FE_8080_FC80_8080;
		8'd6: return 64'h007E_8080_8682_827C;
		8'd7: return 64'h0082_8282_FE82_8282;
		8'd8: return 64'h00FE_1010_1010_10FE;
		8'd9: return 64'h00FE_0808_0888_8870;
		8'd10: return 64'h0090_A0C0_C0A0_9088;
		8'd11: return 64'h0080_8080_8080_80FE;
		8'd12: return 64'h0082_C6AA_9282_8282;
		8'd13: return 64'h0082_C2A2_928A_8682;
		8'd14: return 64'h007C_8282_8282_827C;
		8'd15: return 64'h00FC_8282_FC80_8080;
		8'd16: return 64'h007E_8282_928A_867E;
		8'd17: return 64'h00FC_8282_FC98_8C86;
		8'd18: return 64'h007C_8280_7C02_827C;
		8'd19: return 64'h00FE_1010_1010_1010;
		8'd20: return 64'h0082_8282_8282_82FE;
		8'd21: return 64'h0082_8244_4428_2810;
		8'd22: return 64'h0082_8282_9254_5428;
		8'd23: return 64'h0082_4428_1028_4482;
		8'd24: return 64'h0082_4428_1020_4080;
		8'd25: return 64'h00FE_0408_1020_40FE;
		default: return 64'h0;
	endcase
endfunction

// Colour level of one pixel, from the layout rule and the shadow codes
function automatic int expectPixel(input int px, input int py);
	int row;
	int col;
	logic [63:0] bitmap;
	logic [7:0] line;
	row = py / textPkg::defRowPitch;
	col = (px - textPkg::defXOrigin) / textPkg::glyphSize;
	if (px < textPkg::defXOrigin || py % textPkg::defRowPitch >= textPkg::glyphSize
		|| row >= textPkg::defTextRows) begin
		return 0;
	end
	if (col >= ((row == textPkg::defTextRows - 1) ? textPkg::defLastRowCols
		: textPkg::defTextCols)) begin
		return 0;
	end
	bitmap = glyphBitmap(shadow[row * textPkg::defTextCols + col]);
	line = bitmap[63 - 8 * (py % 8) -: 8];
	// Leftmost pixel is the MSB
	return line[7 - (px - textPkg::defXOrigin) % 8] ? 255 : 0;
endfunction

`endif

// ==== sim/videoGenTb.sv ====
// Testbench for the text-mode pixel generator, checked against a reference pixel model
module videoGenTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int numRandom = 4000;
	// Cycles of all phases, fills and scans included
	localparam int stimCycles = 8 + 2 * 657 + 3 * 26 + 3 * 26 * 64 + 2688 + 6 * 65 + 70
		+ numRandom + 10;

	logic clk;
	logic rstN;
	logic [textPkg::coordW-1:0] x;
	logic [textPkg::coordW-1:0] y;
	textPkg::charWrite_t wr;
	logic [7:0] r;
	logic [7:0] g;
	logic [7:0] b;

	logic [15:0] lfsr = 16'd86;
	int expQ [$];
	int errorCount = 0;
	int checkCount = 0;

	`include "glyphModel.svh"

	videoGen videoGen_i (
		.clk(clk),
		.rstN(rstN),
		.x(x),
		.y(y),
		.wr(wr),
		.r(r),
		.g(g),
		.b(b)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Galois LFSR, one step per bit
	function automatic int takeBits(input int n);
		int val;
		val = 0;
		for (int i = 0; i < n; i++) begin
			val = (val << 1) | int'(lfsr[0]);
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return val;
	endfunction

	function automatic int cellOf(input int row, input int col);
		return row * textPkg::defTextCols + col;
	endfunction

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic writeCell(input int addr, input int code);
		wr.en = 1'b1;
		wr.addr = textPkg::cellAddrW'(addr);
		wr.code = textPkg::glyphCode_t'(code);
		tick();
		wr.en = 1'b0;
	endtask

	task automatic showPixel(input int px, input int py);
		x = textPkg::coordW'(px);
		y = textPkg::coordW'(py);
		tick();
	endtask

	task automatic scanArea(input int x0, input int x1, input int y0, input int y1);
		for (int py = y0; py <= y1; py++) begin
			for (int px = x0; px <= x1; px++) begin
				showPixel(px, py);
			end
		end
	endtask

	// 8x8 area of one cell
	task automatic scanCell(input int row, input int col);
		scanArea(16 + col * 8, 23 + col * 8, row * 16, row * 16 + 7);
	endtask

	// Write of this edge is seen by the coordinate sampled with it
	always @(posedge clk) begin
		if (!rstN) begin
			expQ.delete();
		end else begin
			if (wr.en && wr.addr < numCells) begin
				shadow[wr.addr] = wr.code;
			end
			expQ.push_back(expectPixel(int'(x), int'(y)));
			if (expQ.size() > 3) begin
				void'(expQ.pop_front());
			end
		end
	end

	// Output after edge N holds the coordinate driven after edge N-3
	always @(negedge clk) begin
		int expVal;
		expVal = (expQ.size() == 3) ? expQ[0] : 0;
		checkCount++;
		if (r !== 8'(expVal)) begin
			errorCount++;
			$display("[ERROR] %0t r expected %0d got %0d", $time, expVal, r);
		end
		if (g !== 8'(expVal)) begin
			errorCount++;
			$display("[ERROR] %0t g expected %0d got %0d", $time, expVal, g);
		end
		if (b !== 8'(expVal)) begin
			errorCount++;
			$display("[ERROR] %0t b expected %0d got %0d", $time, expVal, b);
		end
	end

	initial begin
		rstN = 1'b0;
		x = '0;
		y = '0;
		wr = '0;
		repeat (8) @(posedge clk);
		#1;
		rstN = 1'b1;
		// Blank every cell while the scan sits off text
		for (int i = 0; i < numCells; i++) begin
			writeCell(i, 26);
		end
		for (int i = 0; i < 26; i++) begin
			writeCell(cellOf(0, i), i);
			writeCell(cellOf(4, 40 + i), (i + 13) % 26);
			writeCell(cellOf(8, 7 + i), 25 - i);
		end
		for (int i = 0; i < 26; i++) begin
			scanCell(0, i);
			scanCell(4, 40 + i);
			scanCell(8, 7 + i);
		end
		// Off-text areas next to stored letters
		scanArea(0, 15, 0, 7);
		scanArea(16, 79, 8, 15);
		// Columns past the end of row 7 alias onto letters of row 8
		scanArea(640, 703, 112, 119);
		scanArea(280, 343, 128, 135);
		scanArea(16, 79, 144, 159);
		// Blank and undefined codes
		for (int c = 26; c < 32; c++) begin
			writeCell(cellOf(2, c - 26), c);
		end
		for (int c = 0; c < 6; c++) begin
			scanCell(2, c);
		end
		// A becomes M while one of its pixels is being read
		x = 10'd16;
		y = 10'd1;
		tick();
		writeCell(cellOf(0, 0), 12);
		tick();
		tick();
		scanCell(0, 0);
		for (int i = 0; i < numCells; i++) begin
			writeCell(i, takeBits(5));
		end
		for (int i = 0; i < numRandom; i++) begin
			showPixel(takeBits(10) % 704, takeBits(8) % 160);
		end
		x = '0;
		y = '0;
		repeat (6) tick();
		$display("Samples checked: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	initial begin
		#(stimCycles * 8 + 1000);
		$display("Run did not finish in time and was stopped by the watchdog");
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+sim
common/textPkg.sv
verilog/charRam.sv
verilog/fontRom.sv
verilog/textCellMap.sv
verilog/videoGen.sv
sim/videoGenTb.sv

// ==== Makefile ====
# Verilator build and run for the text-mode pixel generator
SHELL := /bin/bash

VERILATOR ?= verilator
TOP ?= videoGenTb
FILELIST ?= list.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0
FAIL_MSG ?= CHECKS FAILED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
